// File: hw/soc_pkg.sv
`default_nettype none

package soc_pkg;

	// bus word and address widths
	localparam int archbitsz = 32;
	localparam int addrbitsz = archbitsz - $clog2(archbitsz / 8);
	localparam int selbitsz = archbitsz / 8;

	// op codes, code 3 behaves as a read
	localparam logic [1:0] op_none = 2'd0;
	localparam logic [1:0] op_write = 2'd1;
	localparam logic [1:0] op_read = 2'd2;

	// slots on the interconnect
	localparam int slot_devtbl = 0;
	localparam int slot_ram = 1;
	localparam int slot_invalid = 2;
	localparam int slot_count = 3;

	// map sizes in words
	localparam int mapsz_devtbl = 64;
	localparam int mapsz_ram = 256;
	localparam int mapsz_invalid = 1024;

	// each base is the running sum of the earlier map sizes
	localparam int base_devtbl = 0;
	localparam int base_ram = base_devtbl + mapsz_devtbl;
	localparam int base_invalid = base_ram + mapsz_ram;

	// device ids reported through the device table
	localparam int id_devtbl = 7;
	localparam int id_ram = 1;
	localparam int id_invalid = 0;

	// device table word that holds the software reset bits
	localparam int rstctrl_word = 62;

	// reset stretch counter
	localparam int rst_cntr_bitsz = 4;

endpackage

`default_nettype wire

// File: hw/pi1_if.sv
`timescale 1ns/1ns
`default_nettype none

interface pi1_if;

	logic [1:0] op;
	logic [soc_pkg::addrbitsz-1:0] addr;
	logic [soc_pkg::archbitsz-1:0] wdata;
	logic [soc_pkg::archbitsz-1:0] rdata;
	logic [soc_pkg::selbitsz-1:0] sel;
	// transfer ends on the edge where rdy is high
	logic rdy;

	modport master (
		output op,
		output addr,
		output wdata,
		output sel,
		input rdata,
		input rdy
	);

	modport slave (
		input op,
		input addr,
		input wdata,
		input sel,
		output rdata,
		output rdy
	);

endinterface

`default_nettype wire

// File: hw/bus_router.sv
`timescale 1ns/1ns
`default_nettype none

module bus_router (
	pi1_if.slave m,
	pi1_if.master s_devtbl,
	pi1_if.master s_ram
);

	logic [soc_pkg::addrbitsz-1:0] off_devtbl;
	logic [soc_pkg::addrbitsz-1:0] off_ram;
	logic hit_devtbl;
	logic hit_ram;
	logic req;
	logic [1:0] slot;

	assign req = (m.op != soc_pkg::op_none);

	// offset into each window, an address below the base wraps and misses
	assign off_devtbl = m.addr - soc_pkg::base_devtbl[soc_pkg::addrbitsz-1:0];
	assign off_ram = m.addr - soc_pkg::base_ram[soc_pkg::addrbitsz-1:0];

	assign hit_devtbl = (off_devtbl < soc_pkg::mapsz_devtbl[soc_pkg::addrbitsz-1:0]);
	assign hit_ram = (off_ram < soc_pkg::mapsz_ram[soc_pkg::addrbitsz-1:0]);

	// anything outside the real windows falls to the invalid slot
	assign slot = hit_devtbl ? soc_pkg::slot_devtbl[1:0] :
		hit_ram ? soc_pkg::slot_ram[1:0] :
		soc_pkg::slot_invalid[1:0];

	// request side, op only reaches the selected slave
	assign s_devtbl.op = (slot == soc_pkg::slot_devtbl[1:0]) ? m.op : soc_pkg::op_none;
	assign s_devtbl.addr = off_devtbl;
	assign s_devtbl.wdata = m.wdata;
	assign s_devtbl.sel = m.sel;

	assign s_ram.op = (slot == soc_pkg::slot_ram[1:0]) ? m.op : soc_pkg::op_none;
	assign s_ram.addr = off_ram;
	assign s_ram.wdata = m.wdata;
	assign s_ram.sel = m.sel;

	// response mux
	always_comb begin
		m.rdata = '0;
		m.rdy = 1'b0;
		case (slot)
			soc_pkg::slot_devtbl[1:0]: begin
				m.rdata = s_devtbl.rdata;
				m.rdy = s_devtbl.rdy;
			end
			soc_pkg::slot_ram[1:0]: begin
				m.rdata = s_ram.rdata;
				m.rdy = s_ram.rdy;
			end
			default: begin
				// invalid device, reads zero and drops writes
				m.rdy = req;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hw/dev_table.sv
`timescale 1ns/1ns
`default_nettype none

module dev_table (
	input wire logic clk120mhz,
	input wire logic sys_rst_i,
	pi1_if.slave bus,
	output logic rst0_o,
	output logic rst1_o
);

	logic [soc_pkg::archbitsz-1:0] dev_id [soc_pkg::slot_count];
	logic [soc_pkg::archbitsz-1:0] dev_mapsz [soc_pkg::slot_count];
	logic [$clog2(soc_pkg::slot_count)-1:0] tbl_idx;
	logic [soc_pkg::archbitsz-1:0] rd_word;
	logic [soc_pkg::archbitsz-1:0] rdata_q;
	logic rdy_q;
	logic rst0_q;
	logic rst1_q;
	logic accept;
	logic is_ctrl;

	// id and map size per slot, as software walks them
	assign dev_id[soc_pkg::slot_devtbl] = soc_pkg::id_devtbl;
	assign dev_id[soc_pkg::slot_ram] = soc_pkg::id_ram;
	assign dev_id[soc_pkg::slot_invalid] = soc_pkg::id_invalid;
	assign dev_mapsz[soc_pkg::slot_devtbl] = soc_pkg::mapsz_devtbl;
	assign dev_mapsz[soc_pkg::slot_ram] = soc_pkg::mapsz_ram;
	assign dev_mapsz[soc_pkg::slot_invalid] = soc_pkg::mapsz_invalid;

	// a request is taken once, the cycle with rdy high is its last
	assign accept = (bus.op != soc_pkg::op_none) && !rdy_q;
	assign is_ctrl = (bus.addr == soc_pkg::rstctrl_word[soc_pkg::addrbitsz-1:0]);

	// word 2k is the id of slot k, word 2k+1 its map size
	assign tbl_idx = bus.addr[$clog2(soc_pkg::slot_count):1];

	always_comb begin
		rd_word = '0;
		if (is_ctrl) begin
			rd_word = {{(soc_pkg::archbitsz - 2){1'b0}}, rst1_q, rst0_q};
		end else if (bus.addr[soc_pkg::addrbitsz-1:1] <
			soc_pkg::slot_count[soc_pkg::addrbitsz-2:0]) begin
			rd_word = bus.addr[0] ? dev_mapsz[tbl_idx] : dev_id[tbl_idx];
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (sys_rst_i) begin
			rdy_q <= 1'b0;
		end else begin
			rdy_q <= accept;
		end
	end

	always_ff @(posedge clk120mhz) begin
		rdata_q <= rd_word;
	end

	// reset control, sys_rst also withdraws a pending request
	always_ff @(posedge clk120mhz) begin
		if (sys_rst_i) begin
			rst0_q <= 1'b0;
			rst1_q <= 1'b0;
		end else if (accept && bus.op == soc_pkg::op_write && is_ctrl && bus.sel[0]) begin
			rst0_q <= bus.wdata[0];
			rst1_q <= bus.wdata[1];
		end
	end

	assign bus.rdata = rdata_q;
	assign bus.rdy = rdy_q;
	assign rst0_o = rst0_q;
	assign rst1_o = rst1_q;

endmodule

`default_nettype wire

// File: hw/reset_seq.sv
`timescale 1ns/1ns
`default_nettype none

module reset_seq (
	input wire logic clk120mhz,
	input wire logic rst_p,
	input wire logic rst0_i,
	input wire logic rst1_i,
	output logic sys_rst_o,
	output logic cold_rst_o,
	output logic pwroff_o
);

	logic [soc_pkg::rst_cntr_bitsz-1:0] rst_cntr;
	logic pwroff_q;
	logic sw_cold;
	logic sw_warm;
	logic sw_pwroff;

	// request decode from the two control bits
	assign sw_cold = rst0_i && rst1_i;
	assign sw_warm = !rst0_i && rst1_i;
	assign sw_pwroff = rst0_i && !rst1_i;

	// stretch reset for a full count after the last request
	always_ff @(posedge clk120mhz) begin
		if (rst_p || sw_warm || sw_cold) begin
			rst_cntr <= '1;
		end else if (rst_cntr != '0) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	// power-off holds until the external reset
	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (sw_pwroff) begin
			pwroff_q <= 1'b1;
		end
	end

	assign sys_rst_o = rst_p || pwroff_q || (rst_cntr != '0);
	assign cold_rst_o = sw_cold;
	assign pwroff_o = pwroff_q;

endmodule

`default_nettype wire

// File: hw/scratch_ram.sv
`timescale 1ns/1ns
`default_nettype none

module scratch_ram (
	input wire logic clk120mhz,
	input wire logic sys_rst_i,
	pi1_if.slave bus
);

	logic [soc_pkg::archbitsz-1:0] mem [soc_pkg::mapsz_ram];
	logic [$clog2(soc_pkg::mapsz_ram)-1:0] word_idx;
	logic [soc_pkg::archbitsz-1:0] rdata_q;
	logic stage1_q;
	logic stage2_q;
	logic accept;

	// router keeps the offset inside the window
	assign word_idx = bus.addr[$clog2(soc_pkg::mapsz_ram)-1:0];

	// no new request while one is in flight
	assign accept = (bus.op != soc_pkg::op_none) && !stage1_q && !stage2_q;

	// stage1 does the access, stage2 raises rdy
	always_ff @(posedge clk120mhz) begin
		if (sys_rst_i) begin
			stage1_q <= 1'b0;
			stage2_q <= 1'b0;
		end else begin
			stage1_q <= accept;
			stage2_q <= stage1_q;
		end
	end

	// byte merge on write, request is still held during stage1
	always_ff @(posedge clk120mhz) begin
		if (stage1_q && bus.op == soc_pkg::op_write) begin
			for (int b = 0; b < soc_pkg::selbitsz; b++) begin
				if (bus.sel[b]) begin
					mem[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (stage1_q) begin
			rdata_q <= mem[word_idx];
		end
	end

	assign bus.rdata = rdata_q;
	assign bus.rdy = stage2_q;

endmodule

`default_nettype wire

// File: hw/soc_top.sv
`timescale 1ns/1ns
`default_nettype none

module soc_top (
	input wire logic clk120mhz,
	input wire logic rst_p,
	input wire logic [1:0] m_op_i,
	input wire logic [soc_pkg::addrbitsz-1:0] m_addr_i,
	input wire logic [soc_pkg::archbitsz-1:0] m_data_i,
	input wire logic [soc_pkg::selbitsz-1:0] m_sel_i,
	output logic [soc_pkg::archbitsz-1:0] m_data_o,
	output logic m_rdy_o,
	output logic sys_rst_o,
	output logic cold_rst_o,
	output logic pwroff_o
);

	logic rst0_w;
	logic rst1_w;
	logic sys_rst_w;

	pi1_if m_bus ();
	pi1_if devtbl_bus ();
	pi1_if ram_bus ();

	// external master onto the interconnect
	assign m_bus.op = m_op_i;
	assign m_bus.addr = m_addr_i;
	assign m_bus.wdata = m_data_i;
	assign m_bus.sel = m_sel_i;
	assign m_data_o = m_bus.rdata;
	assign m_rdy_o = m_bus.rdy;

	assign sys_rst_o = sys_rst_w;

	bus_router router0 (
		.m(m_bus.slave),
		.s_devtbl(devtbl_bus.master),
		.s_ram(ram_bus.master)
	);

	dev_table devtbl0 (
		.clk120mhz(clk120mhz),
		.sys_rst_i(sys_rst_w),
		.bus(devtbl_bus.slave),
		.rst0_o(rst0_w),
		.rst1_o(rst1_w)
	);

	// software reset and power control
	reset_seq rstseq0 (
		.clk120mhz(clk120mhz),
		.rst_p(rst_p),
		.rst0_i(rst0_w),
		.rst1_i(rst1_w),
		.sys_rst_o(sys_rst_w),
		.cold_rst_o(cold_rst_o),
		.pwroff_o(pwroff_o)
	);

	// stands in for the sdram path
	scratch_ram ram0 (
		.clk120mhz(clk120mhz),
		.sys_rst_i(sys_rst_w),
		.bus(ram_bus.slave)
	);

endmodule

`default_nettype wire

// File: test/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// reference copy of the scratch ram, one entry per word
logic [31:0] ram_model [soc_pkg::mapsz_ram];

// bus word address of ram word idx
function automatic logic [soc_pkg::addrbitsz-1:0] ram_addr(input int idx);
	int a;
	a = soc_pkg::base_ram + idx;
	return a[soc_pkg::addrbitsz-1:0];
endfunction

function automatic logic [soc_pkg::addrbitsz-1:0] table_addr(input int w);
	int a;
	a = soc_pkg::base_devtbl + w;
	return a[soc_pkg::addrbitsz-1:0];
endfunction

// expected table contents, control word taken as cleared
function automatic logic [31:0] table_word(input int w);
	case (w)
		2 * soc_pkg::slot_devtbl: return soc_pkg::id_devtbl;
		2 * soc_pkg::slot_devtbl + 1: return soc_pkg::mapsz_devtbl;
		2 * soc_pkg::slot_ram: return soc_pkg::id_ram;
		2 * soc_pkg::slot_ram + 1: return soc_pkg::mapsz_ram;
		2 * soc_pkg::slot_invalid: return soc_pkg::id_invalid;
		2 * soc_pkg::slot_invalid + 1: return soc_pkg::mapsz_invalid;
		default: return 32'h0;
	endcase
endfunction

// byte lanes with sel set take the new data
function automatic void model_write(input int idx, input logic [31:0] data,
	input logic [3:0] sel);
	for (int b = 0; b < soc_pkg::selbitsz; b++) begin
		if (sel[b]) begin
			ram_model[idx][8*b +: 8] = data[8*b +: 8];
		end
	end
endfunction

// fill value, every address bit changes the result
function automatic logic [31:0] fill_word(input int idx);
	return (idx + 1) * 32'h9e3779b9;
endfunction

`endif

// File: test/tb_soc.sv
`timescale 1ns/1ns
`default_nettype none

module tb_soc;

	logic clk120mhz;
	logic rst_p;
	logic [1:0] m_op_i;
	logic [soc_pkg::addrbitsz-1:0] m_addr_i;
	logic [soc_pkg::archbitsz-1:0] m_data_i;
	logic [soc_pkg::selbitsz-1:0] m_sel_i;
	logic [soc_pkg::archbitsz-1:0] m_data_o;
	logic m_rdy_o;
	logic sys_rst_o;
	logic cold_rst_o;
	logic pwroff_o;
	integer seed;
	int errors = 0;
	int test_start_errors = 0;
	int tests_ok = 0;
	int tests_bad = 0;
	int cold_hi_cnt = 0;
	int pwr_hi_cnt = 0;

	`include "tb_model.svh"

	soc_top dut0 (
		.clk120mhz(clk120mhz),
		.rst_p(rst_p),
		.m_op_i(m_op_i),
		.m_addr_i(m_addr_i),
		.m_data_i(m_data_i),
		.m_sel_i(m_sel_i),
		.m_data_o(m_data_o),
		.m_rdy_o(m_rdy_o),
		.sys_rst_o(sys_rst_o),
		.cold_rst_o(cold_rst_o),
		.pwroff_o(pwroff_o)
	);

	initial begin
		clk120mhz = 1'b0;
		forever #20 clk120mhz = ~clk120mhz;
	end

	// count cycles with cold or power-off seen, sampled mid-cycle
	always @(negedge clk120mhz) begin
		if (cold_rst_o) begin
			cold_hi_cnt++;
		end
		if (pwroff_o) begin
			pwr_hi_cnt++;
		end
	end

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp) else begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic expect_true(input bit cond, input string what);
		assert (cond) else begin
			$display("CHECK FAILED at %0t: %s", $time, what);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (errors == test_start_errors) begin
			tests_ok++;
			$display("test %s: ok", name);
		end else begin
			tests_bad++;
			$display("test %s: %0d errors", name, errors - test_start_errors);
		end
		test_start_errors = errors;
	endtask

	// one transfer, called and returning 2 ns after a rising edge
	task automatic bus_xfer(input logic [1:0] op, input logic [soc_pkg::addrbitsz-1:0] addr,
		input logic [31:0] wdata, input logic [3:0] sel, output logic [31:0] rdata);
		bit done;
		done = 1'b0;
		rdata = 32'h0;
		m_op_i = op;
		m_addr_i = addr;
		m_data_i = wdata;
		m_sel_i = sel;
		for (int n = 0; n < 20 && !done; n++) begin
			@(negedge clk120mhz);
			if (m_rdy_o) begin
				done = 1'b1;
				rdata = m_data_o;
			end
			@(posedge clk120mhz);
			#2;
		end
		m_op_i = soc_pkg::op_none;
		if (!done) begin
			$display("ERROR at %0t: transfer to address %h got no ready", $time, addr);
			errors++;
		end
	endtask

	task automatic wait_level(input bit use_pwroff, input logic level, input int limit,
		input string what);
		bit hit;
		hit = 1'b0;
		for (int n = 0; n < limit && !hit; n++) begin
			@(negedge clk120mhz);
			hit = use_pwroff ? (pwroff_o == level) : (sys_rst_o == level);
			@(posedge clk120mhz);
			#2;
		end
		if (!hit) begin
			$display("ERROR at %0t: timed out waiting for %s", $time, what);
			errors++;
		end
	endtask

	initial begin
		logic [31:0] rd;
		logic [31:0] wd;
		logic [3:0] sel;
		logic [1:0] op;
		int r;
		int idx;
		int a;
		int cold_before;
		int pwr_before;
		int low_cycles;
		seed = 92;
		rst_p = 1'b1;
		m_op_i = soc_pkg::op_none;
		m_addr_i = '0;
		m_data_i = '0;
		m_sel_i = '0;
		repeat (10) @(posedge clk120mhz);
		#2;
		rst_p = 1'b0;

		wait_level(1'b0, 1'b0, 100, "sys_rst_o low after reset");
		expect_true(cold_hi_cnt == 0 && pwr_hi_cnt == 0, "cold_rst_o or pwroff_o high at reset");
		finish_test("reset state");

		for (int w = 0; w < soc_pkg::mapsz_devtbl; w++) begin
			bus_xfer(soc_pkg::op_read, table_addr(w), 32'h0, 4'hf, rd);
			check_word(rd, table_word(w), $sformatf("device table word %0d", w));
		end
		finish_test("device table");

		// known contents everywhere before the random traffic
		for (int i = 0; i < soc_pkg::mapsz_ram; i++) begin
			bus_xfer(soc_pkg::op_write, ram_addr(i), fill_word(i), 4'hf, rd);
			model_write(i, fill_word(i), 4'hf);
		end
		for (int i = 0; i < 200; i++) begin
			r = $random(seed);
			idx = r & (soc_pkg::mapsz_ram - 1);
			wd = $random(seed);
			r = $random(seed);
			sel = r[3:0];
			bus_xfer(soc_pkg::op_write, ram_addr(idx), wd, sel, rd);
			model_write(idx, wd, sel);
			r = $random(seed);
			idx = r & (soc_pkg::mapsz_ram - 1);
			// op code 3 counts as a read too
			op = r[12] ? 2'd3 : soc_pkg::op_read;
			bus_xfer(op, ram_addr(idx), 32'h0, 4'hf, rd);
			check_word(rd, ram_model[idx], $sformatf("ram word %0d", idx));
		end
		finish_test("ram random");

		bus_xfer(soc_pkg::op_write, ram_addr(17), 32'h5a5a_c3c3, 4'hf, rd);
		model_write(17, 32'h5a5a_c3c3, 4'hf);
		for (int i = 0; i < 50; i++) begin
			r = $random(seed);
			a = r & 32'h3fff_ffff;
			if (a < soc_pkg::base_invalid) begin
				a = a + soc_pkg::base_invalid;
			end
			wd = $random(seed);
			op = r[31] ? soc_pkg::op_write : soc_pkg::op_read;
			bus_xfer(op, a[soc_pkg::addrbitsz-1:0], wd, 4'hf, rd);
			if (op == soc_pkg::op_read) begin
				check_word(rd, 32'h0, $sformatf("invalid device at %h", a));
			end
		end
		bus_xfer(soc_pkg::op_read, ram_addr(17), 32'h0, 4'hf, rd);
		check_word(rd, ram_model[17], "ram word 17 after invalid accesses");
		finish_test("invalid device");

		cold_before = cold_hi_cnt;
		pwr_before = pwr_hi_cnt;
		bus_xfer(soc_pkg::op_write, table_addr(soc_pkg::rstctrl_word), 32'h2, 4'h1, rd);
		wait_level(1'b0, 1'b1, 20, "sys_rst_o high on warm reset");
		wait_level(1'b0, 1'b0, 100, "sys_rst_o low after warm reset");
		bus_xfer(soc_pkg::op_read, table_addr(soc_pkg::rstctrl_word), 32'h0, 4'hf, rd);
		check_word(rd, 32'h0, "control register after warm reset");
		bus_xfer(soc_pkg::op_read, ram_addr(17), 32'h0, 4'hf, rd);
		check_word(rd, ram_model[17], "ram word 17 after warm reset");
		expect_true(cold_hi_cnt == cold_before && pwr_hi_cnt == pwr_before,
			"cold_rst_o or pwroff_o raised by warm reset");
		finish_test("warm reset");

		cold_before = cold_hi_cnt;
		bus_xfer(soc_pkg::op_write, table_addr(soc_pkg::rstctrl_word), 32'h3, 4'h1, rd);
		wait_level(1'b0, 1'b1, 20, "sys_rst_o high on cold reset");
		wait_level(1'b0, 1'b0, 100, "sys_rst_o low after cold reset");
		expect_true(cold_hi_cnt > cold_before, "cold_rst_o never raised by cold request");
		@(negedge clk120mhz);
		expect_true(!cold_rst_o && !pwroff_o, "cold_rst_o or pwroff_o high after cold reset");
		@(posedge clk120mhz);
		#2;
		bus_xfer(soc_pkg::op_read, table_addr(soc_pkg::rstctrl_word), 32'h0, 4'hf, rd);
		check_word(rd, 32'h0, "control register after cold reset");
		bus_xfer(soc_pkg::op_write, table_addr(soc_pkg::rstctrl_word), 32'h1, 4'h1, rd);
		wait_level(1'b1, 1'b1, 20, "pwroff_o high on power-off");
		low_cycles = 0;
		repeat (100) begin
			@(negedge clk120mhz);
			if (!sys_rst_o) begin
				low_cycles++;
			end
		end
		expect_true(low_cycles == 0, "sys_rst_o dropped during power-off");
		@(posedge clk120mhz);
		#2;
		rst_p = 1'b1;
		repeat (2) @(posedge clk120mhz);
		#2;
		rst_p = 1'b0;
		wait_level(1'b1, 1'b0, 20, "pwroff_o low after rst_p");
		wait_level(1'b0, 1'b0, 100, "sys_rst_o low after rst_p");
		finish_test("cold reset and power-off");

		$display("summary: %0d ok, %0d failing", tests_ok, tests_bad);
		if (tests_bad == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+test
hw/soc_pkg.sv
hw/pi1_if.sv
hw/bus_router.sv
hw/dev_table.sv
hw/reset_seq.sv
hw/scratch_ram.sv
hw/soc_top.sv
test/tb_soc.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_soc -f src.f -o tb_soc

out=$(./obj_dir/tb_soc)
echo "$out"

if echo "$out" | grep -q "TESTS PASSED"; then
	exit 0
else
	exit 1
fi
